// File: Bender.yml
package:
  name: fftCore

sources:
  - fftPkg.sv
  - fftControl.sv
  - stageCounter.sv
  - addressGenerator.sv
  - twiddleRom.sv
  - butterfly.sv
  - sampleMemory.sv
  - fftCore.sv
  - target: test
    files:
      - tbClock.sv
      - fftCore_sva.sv
      - tb_fftCore.sv

// File: addressGenerator.sv
module addressGenerator #(
    parameter int FftSize = 1024
) (
    input  logic [fftPkg::StageWidth-1:0] stage,
    input  logic [fftPkg::AddrWidth-2:0]  cycle,
    input  logic                          run,
    output fftPkg::bflyReqT               req
);
    import fftPkg::*;

    localparam int Log2Size = $clog2(FftSize);
    localparam int HalfSize = FftSize / 2;

    logic [StageWidth-1:0] zeroPos;    // Bit of the address that picks A or B
    logic [AddrWidth-1:0]  cycleExt;
    logic [AddrWidth-1:0]  lowMask;
    logic [AddrWidth-1:0]  addrA;
    logic [AddrWidth-1:0]  span;       // Distance between the two legs
    logic [AddrWidth-1:0]  twLinear;

    always_comb begin
        zeroPos  = StageWidth'(Log2Size - 1) - stage;
        cycleExt = AddrWidth'(cycle);
        lowMask  = (AddrWidth'(1) << zeroPos) - 1'b1;

        // Bits above zeroPos move up by one, so a zero lands in the gap
        addrA = ((cycleExt & ~lowMask) << 1) | (cycleExt & lowMask);
        span  = AddrWidth'(HalfSize) >> stage;

        // Position inside the group, scaled by the stage
        twLinear = (cycleExt << stage) & AddrWidth'(HalfSize - 1);
    end

    always_comb begin
        req.addrA = addrA;
        req.addrB = addrA + span;
        req.twIdx = (AddrWidth-1)'(bitReverse(twLinear, Log2Size - 1));  // ROM is stored reversed
        req.valid = run;
    end

endmodule

// File: butterfly.sv
module butterfly (
    input  logic                        clk,
    input  logic                        arstN,
    input  logic                        inValid,   // With the request, a cycle before a and b
    input  fftPkg::sampleU              a,
    input  fftPkg::sampleU              b,
    input  fftPkg::twiddleT             tw,
    input  logic [fftPkg::AddrWidth-1:0] inAddrA,
    input  logic [fftPkg::AddrWidth-1:0] inAddrB,
    output logic                        outValid,
    output fftPkg::sampleU              x,
    output fftPkg::sampleU              y,
    output logic [fftPkg::AddrWidth-1:0] outAddrA,
    output logic [fftPkg::AddrWidth-1:0] outAddrB
);
    import fftPkg::*;

    localparam int ProdWidth = 2 * SampleWidth + 2;

    logic                          validMid;
    logic [AddrWidth-1:0]          addrAMid;
    logic [AddrWidth-1:0]          addrBMid;
    logic signed [SampleWidth:0]   sumRe;
    logic signed [SampleWidth:0]   sumIm;
    logic signed [SampleWidth:0]   difRe;
    logic signed [SampleWidth:0]   difIm;
    logic signed [ProdWidth-1:0]   prodRe;
    logic signed [ProdWidth-1:0]   prodIm;
    logic signed [ProdWidth-1:0]   shiftRe;
    logic signed [ProdWidth-1:0]   shiftIm;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // DIF butterfly, both legs halved
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_comb begin
        sumRe = a.cplx.re + b.cplx.re;  // One guard bit, dropped again by the halving
        sumIm = a.cplx.im + b.cplx.im;
        difRe = a.cplx.re - b.cplx.re;
        difIm = a.cplx.im - b.cplx.im;

        // The twiddle is cos + j*negSin
        prodRe = difRe * tw.cos - difIm * tw.negSin;
        prodIm = difRe * tw.negSin + difIm * tw.cos;

        shiftRe = prodRe >>> (TwiddleFrac + 1);
        shiftIm = prodIm >>> (TwiddleFrac + 1);
    end

    always_ff @(posedge clk) begin
        x.cplx.re <= sumRe[SampleWidth:1];
        x.cplx.im <= sumIm[SampleWidth:1];
        y.cplx.re <= shiftRe[SampleWidth-1:0];
        y.cplx.im <= shiftIm[SampleWidth-1:0];
        addrAMid  <= inAddrA;  // Waits out the memory read
        addrBMid  <= inAddrB;
        outAddrA  <= addrAMid;
        outAddrB  <= addrBMid;
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            validMid <= 1'b0;
            outValid <= 1'b0;
        end else begin
            validMid <= inValid;
            outValid <= validMid;
        end
    end

endmodule

// File: fftControl.sv
module fftControl #(
    parameter int DrainCycles = 3  // Latency from a request issue to its write-back
) (
    input  logic clk,
    input  logic arstN,
    input  logic start,
    input  logic lastCycle,
    input  logic lastStage,
    output logic run,
    output logic clear,
    output logic busy,
    output logic done
);
    import fftPkg::*;

    localparam int DrainWidth = $clog2(DrainCycles + 1);

    fftStateT              state;
    fftStateT              nextState;
    logic [DrainWidth-1:0] drainCount;
    logic                  drainEnd;
    logic                  finalPass;  // The stage just issued was the last one

    assign drainEnd = (drainCount == DrainWidth'(DrainCycles - 1));

    always_comb begin
        nextState = state;
        case (state)
            IDLE: begin
                if (start) begin  // A start while busy never reaches this branch
                    nextState = RUN;
                end
            end
            RUN: begin
                if (lastCycle) begin
                    nextState = DRAIN;
                end
            end
            DRAIN: begin
                if (drainEnd) begin
                    nextState = finalPass ? DONE : RUN;
                end
            end
            default: nextState = IDLE;  // DONE lasts exactly one cycle
        endcase
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            state      <= IDLE;
            drainCount <= '0;
            finalPass  <= 1'b0;
        end else begin
            state <= nextState;
            if (state == DRAIN) begin
                drainCount <= drainCount + 1'b1;
            end else begin
                drainCount <= '0;
            end
            if (run && lastCycle) begin
                finalPass <= lastStage;  // Counters have moved on by the time the drain ends
            end
        end
    end

    assign run   = (state == RUN);
    assign clear = (state == IDLE);  // Counters stay at zero between transforms
    assign busy  = (state != IDLE);
    assign done  = (state == DONE);

endmodule

// File: fftCore.sv
module fftCore #(
    parameter int FftSize = 1024
) (
    input  logic                         clk,
    input  logic                         arstN,
    input  logic                         loadEn,
    input  logic [fftPkg::AddrWidth-1:0] loadAddr,
    input  fftPkg::sampleU               loadData,
    input  logic                         start,
    output logic                         busy,
    output logic                         done,
    input  logic [fftPkg::AddrWidth-1:0] readAddr,
    output fftPkg::sampleU               readData
);
    import fftPkg::*;

    logic                  run;
    logic                  clear;
    logic                  lastCycle;
    logic                  lastStage;
    logic [StageWidth-1:0] stage;
    logic [AddrWidth-2:0]  cycle;
    bflyReqT               req;
    sampleU                rdDataA;
    sampleU                rdDataB;
    twiddleT               tw;
    logic                  wbValid;
    sampleU                wbDataA;
    sampleU                wbDataB;
    logic [AddrWidth-1:0]  wbAddrA;
    logic [AddrWidth-1:0]  wbAddrB;
    logic                  hostWrite;

    assign hostWrite = loadEn && !busy;  // The host cannot touch a frame in flight

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Sequencing
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    fftControl u_control (
        .clk       (clk),
        .arstN     (arstN),
        .start     (start),
        .lastCycle (lastCycle),
        .lastStage (lastStage),
        .run       (run),
        .clear     (clear),
        .busy      (busy),
        .done      (done)
    );

    stageCounter #(.FftSize(FftSize)) u_counter (
        .clk       (clk),
        .arstN     (arstN),
        .run       (run),
        .clear     (clear),
        .stage     (stage),
        .cycle     (cycle),
        .lastCycle (lastCycle),
        .lastStage (lastStage)
    );

    addressGenerator #(.FftSize(FftSize)) u_addrGen (
        .stage (stage),
        .cycle (cycle),
        .run   (run),
        .req   (req)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Datapath, three cycles from request to write-back
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    twiddleRom #(.FftSize(FftSize)) u_twiddle (
        .clk   (clk),
        .twIdx (req.twIdx),
        .tw    (tw)
    );

    butterfly u_butterfly (
        .clk      (clk),
        .arstN    (arstN),
        .inValid  (req.valid),
        .a        (rdDataA),
        .b        (rdDataB),
        .tw       (tw),
        .inAddrA  (req.addrA),
        .inAddrB  (req.addrB),
        .outValid (wbValid),
        .x        (wbDataA),
        .y        (wbDataB),
        .outAddrA (wbAddrA),
        .outAddrB (wbAddrB)
    );

    sampleMemory #(.FftSize(FftSize)) u_memory (
        .clk      (clk),
        .loadEn   (hostWrite),
        .loadAddr (loadAddr),
        .loadData (loadData),
        .rdAddrA  (req.addrA),
        .rdAddrB  (req.addrB),
        .wrEn     (wbValid),
        .wrAddrA  (wbAddrA),
        .wrAddrB  (wbAddrB),
        .wrDataA  (wbDataA),
        .wrDataB  (wbDataB),
        .readAddr (readAddr),
        .rdDataA  (rdDataA),
        .rdDataB  (rdDataB),
        .readData (readData)
    );

endmodule

// File: fftCore_sva.sv
module fftCore_sva (
    input logic                          clk,
    input logic                          arstN,
    input logic                          start,
    input logic                          busy,
    input logic                          done,
    input logic                          run,
    input logic                          lastCycle,
    input logic [fftPkg::StageWidth-1:0] stage,
    input logic [fftPkg::AddrWidth-2:0]  cycle
);
    timeunit 1ns;
    timeprecision 1ps;

    int assertFailures = 0;  // Read by the testbench at the end of the run

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Control behavior
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    doneSingle: assert property (@(posedge clk) disable iff (!arstN) done |=> !done)
        else begin
            assertFailures++;
            $error("done stayed high for more than one cycle");
        end

    idleAfterReset: assert property (@(posedge clk) $rose(arstN) |-> !busy && !done)
        else begin
            assertFailures++;
            $error("busy or done active right after reset");
        end

    // A second start in the middle of a stage must leave the counters running on
    startNoRestart: assert property (@(posedge clk) disable iff (!arstN)
        (start && run && !lastCycle) |=> (stage == $past(stage)) && (cycle == $past(cycle) + 1'b1))
        else begin
            assertFailures++;
            $error("start while busy disturbed the stage or cycle counter");
        end

    startKeepsBusy: assert property (@(posedge clk) disable iff (!arstN)
        (start && busy && !done) |=> busy)
        else begin
            assertFailures++;
            $error("start while busy dropped the core out of its transform");
        end

endmodule

// File: fftPkg.sv
package fftPkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Widths shared by the datapath and the testbench
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    localparam int SampleWidth  = 16;                  // One real or imaginary part
    localparam int TwiddleFrac  = 14;                  // Fraction bits of a twiddle
    localparam int TwiddleWidth = TwiddleFrac + 2;     // Q2.14, so 1.0 and -1.0 are exact
    localparam int MaxFftSize   = 1024;
    localparam int AddrWidth    = $clog2(MaxFftSize);  // Any smaller size uses the low bits
    localparam int StageWidth   = $clog2(AddrWidth);

    typedef struct packed {
        logic signed [SampleWidth-1:0] re;
        logic signed [SampleWidth-1:0] im;
    } cplxT;

    // Memory ports move the raw word, the arithmetic reads it as re and im
    typedef union packed {
        cplxT                     cplx;
        logic [2*SampleWidth-1:0] raw;
    } sampleU;

    typedef struct packed {
        logic signed [TwiddleWidth-1:0] cos;
        logic signed [TwiddleWidth-1:0] negSin;
    } twiddleT;

    typedef enum logic [1:0] {IDLE, RUN, DRAIN, DONE} fftStateT;

    typedef struct packed {
        logic [AddrWidth-1:0] addrA;
        logic [AddrWidth-1:0] addrB;
        logic [AddrWidth-2:0] twIdx;
        logic                 valid;
    } bflyReqT;

    // Mirrors the lowest bits of value, the bits above them come back as zero
    function automatic logic [AddrWidth-1:0] bitReverse(
        input logic [AddrWidth-1:0] value,
        input int unsigned          bits
    );
        logic [AddrWidth-1:0] result;
        result = '0;
        for (int i = 0; i < AddrWidth; i++) begin
            if (i < bits) begin
                result[i] = value[bits - 1 - i];
            end
        end
        return result;
    endfunction

endpackage

// File: sampleMemory.sv
module sampleMemory #(
    parameter int FftSize = 1024
) (
    input  logic                         clk,
    input  logic                         loadEn,
    input  logic [fftPkg::AddrWidth-1:0] loadAddr,
    input  fftPkg::sampleU               loadData,
    input  logic [fftPkg::AddrWidth-1:0] rdAddrA,
    input  logic [fftPkg::AddrWidth-1:0] rdAddrB,
    input  logic                         wrEn,
    input  logic [fftPkg::AddrWidth-1:0] wrAddrA,
    input  logic [fftPkg::AddrWidth-1:0] wrAddrB,
    input  fftPkg::sampleU               wrDataA,
    input  fftPkg::sampleU               wrDataB,
    input  logic [fftPkg::AddrWidth-1:0] readAddr,
    output fftPkg::sampleU               rdDataA,
    output fftPkg::sampleU               rdDataB,
    output fftPkg::sampleU               readData
);
    import fftPkg::*;

    localparam int Log2Size = $clog2(FftSize);

    logic [2*SampleWidth-1:0] mem [FftSize];
    logic [AddrWidth-1:0]     readRev;

    // Results sit in bit-reversed order after a DIF pass
    assign readRev = bitReverse(readAddr, Log2Size);

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Write side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk) begin
        if (wrEn) begin
            mem[wrAddrA[Log2Size-1:0]] <= wrDataA.raw;
            mem[wrAddrB[Log2Size-1:0]] <= wrDataB.raw;  // Never equal to wrAddrA
        end else if (loadEn) begin
            mem[loadAddr[Log2Size-1:0]] <= loadData.raw;
        end
    end

    // Read side, every port one cycle behind its address
    always_ff @(posedge clk) begin
        rdDataA.raw  <= mem[rdAddrA[Log2Size-1:0]];
        rdDataB.raw  <= mem[rdAddrB[Log2Size-1:0]];
        readData.raw <= mem[readRev[Log2Size-1:0]];
    end

endmodule

// File: src.f
fftPkg.sv
fftControl.sv
stageCounter.sv
addressGenerator.sv
twiddleRom.sv
butterfly.sv
sampleMemory.sv
fftCore.sv
tbClock.sv
fftCore_sva.sv
tb_fftCore.sv

// File: stageCounter.sv
module stageCounter #(
    parameter int FftSize = 1024
) (
    input  logic                          clk,
    input  logic                          arstN,
    input  logic                          run,
    input  logic                          clear,
    output logic [fftPkg::StageWidth-1:0] stage,
    output logic [fftPkg::AddrWidth-2:0]  cycle,
    output logic                          lastCycle,
    output logic                          lastStage
);
    import fftPkg::*;

    localparam int HalfSize  = FftSize / 2;
    localparam int NumStages = $clog2(FftSize);

    assign lastCycle = (cycle == (AddrWidth-1)'(HalfSize - 1));
    assign lastStage = (stage == StageWidth'(NumStages - 1));

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // One butterfly per cycle, one stage per wrap of the cycle count
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            stage <= '0;
            cycle <= '0;
        end else if (clear) begin
            stage <= '0;
            cycle <= '0;
        end else if (run) begin
            if (lastCycle) begin
                cycle <= '0;
                if (lastStage) begin
                    stage <= '0;
                end else begin
                    stage <= stage + 1'b1;
                end
            end else begin
                cycle <= cycle + 1'b1;
            end
        end
    end

endmodule

// File: tbClock.sv
module tbClock #(
    parameter int Period = 100
) (
    output logic clk
);
    timeunit 1ns;
    timeprecision 1ps;

    initial begin
        clk = 1'b0;
    end

    always #(Period / 2) clk = ~clk;  // Free-running, the testbench ends the run

endmodule

// File: tb_fftCore.sv
module tb_fftCore;
    timeunit 1ns;
    timeprecision 1ps;
    import fftPkg::*;

    localparam int FftSize         = 16;
    localparam int TransformCycles = 4 * (FftSize / 2 + 3) + 1;  // Four stages plus done
    localparam int FrameIoCycles   = 3 * FftSize + 8;            // Load, start and readback
    localparam int NumFrames       = 6;
    localparam int CycleLimit      = NumFrames * (TransformCycles + FrameIoCycles) + 100;
    localparam int Amp             = 1600;

    logic                 clk;
    logic                 arstN;
    logic                 loadEn;
    logic [AddrWidth-1:0] loadAddr;
    sampleU               loadData;
    logic                 start;
    logic                 busy;
    logic                 done;
    logic [AddrWidth-1:0] readAddr;
    sampleU               readData;

    int     errorCount;
    int     checkCount;
    int     cycleCount;
    int     seed;
    sampleU frame [FftSize];
    cplxT   expBins [FftSize];

    tbClock #(.Period(100)) u_clock (.clk(clk));

    fftCore #(.FftSize(FftSize)) u_dut (
        .clk(clk), .arstN(arstN), .loadEn(loadEn), .loadAddr(loadAddr), .loadData(loadData),
        .start(start), .busy(busy), .done(done), .readAddr(readAddr), .readData(readData)
    );

    bind fftCore fftCore_sva u_sva (
        .clk(clk), .arstN(arstN), .start(start), .busy(busy), .done(done), .run(run),
        .lastCycle(lastCycle), .stage(stage), .cycle(cycle)
    );

    task automatic checkValue(input string testName, input string what,
                              input logic signed [31:0] expected,
                              input logic signed [31:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("FAIL %s: %s expected %0d, actual %0d", testName, what, expected, actual);
        end
    endtask

    task automatic clearFrame();
        for (int i = 0; i < FftSize; i++) begin
            frame[i].raw = '0;
            expBins[i]   = '0;
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Load a frame, run one transform, read every bin in natural order
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    task automatic runFrame(input string testName, input bit injectStart);
        int cycles;
        int doneCount;
        cycles    = 0;
        doneCount = 0;
        for (int i = 0; i < FftSize; i++) begin
            @(posedge clk);
            loadEn   <= 1'b1;
            loadAddr <= AddrWidth'(i);
            loadData <= frame[i];
        end
        @(posedge clk);
        loadEn <= 1'b0;
        start  <= 1'b1;
        @(posedge clk);
        start <= 1'b0;
        while (doneCount == 0) begin
            @(negedge clk);
            checkValue(testName, "busy while running", 1, busy);
            if (done) begin
                doneCount++;
            end
            cycles++;
            @(posedge clk);
            start <= injectStart && (cycles == 13);  // Lands in the second stage's issue
        end
        repeat (3) begin
            @(negedge clk);
            if (done) begin
                doneCount++;  // A stray second pulse
            end
        end
        checkValue(testName, "done pulses", 1, doneCount);
        checkValue(testName, "busy after done", 0, busy);
        for (int k = 0; k < FftSize; k++) begin
            @(posedge clk);
            readAddr <= AddrWidth'(k);
            @(posedge clk);
            @(negedge clk);
            checkValue(testName, $sformatf("bin %0d re", k), expBins[k].re, readData.cplx.re);
            checkValue(testName, $sformatf("bin %0d im", k), expBins[k].im, readData.cplx.im);
        end
    endtask

    // A scaled transform of an impulse is flat at amp/FftSize
    task automatic fillImpulse(input int amp);
        clearFrame();
        frame[0].cplx.re = SampleWidth'(amp);
        for (int k = 0; k < FftSize; k++) begin
            expBins[k].re = SampleWidth'(amp / FftSize);
        end
    endtask

    // A, -jA, -A, jA rotates once every four samples, so all energy sits in bin 3N/4
    task automatic fillQuarterRate();
        clearFrame();
        for (int i = 0; i < FftSize; i++) begin
            case (i % 4)
                0: frame[i].cplx.re = SampleWidth'(Amp);
                1: frame[i].cplx.im = SampleWidth'(-Amp);
                2: frame[i].cplx.re = SampleWidth'(-Amp);
                default: frame[i].cplx.im = SampleWidth'(Amp);
            endcase
        end
        expBins[FftSize * 3 / 4].re = SampleWidth'(Amp);
    endtask

    task automatic impulseTest();
        fillImpulse(Amp);
        runFrame("impulse", 1'b0);
    endtask

    task automatic dcTest();
        logic [31:0] word;
        word = $random(seed);
        clearFrame();
        for (int i = 0; i < FftSize; i++) begin
            frame[i].cplx.re = word[15:0] & 16'hFFF0;  // Cleared low bits keep every halving exact
            frame[i].cplx.im = word[31:16] & 16'hFFF0;
        end
        expBins[0] = frame[0].cplx;
        runFrame("dc", 1'b0);
    endtask

    task automatic nyquistTest();
        clearFrame();
        for (int i = 0; i < FftSize; i++) begin
            frame[i].cplx.re = (i % 2 == 0) ? SampleWidth'(Amp) : SampleWidth'(-Amp);
        end
        expBins[FftSize / 2].re = SampleWidth'(Amp);
        runFrame("nyquist", 1'b0);
    endtask

    task automatic quarterRateTest();
        fillQuarterRate();
        runFrame("quarter rate", 1'b0);
    endtask

    task automatic controlTest();
        fillQuarterRate();
        runFrame("start while busy", 1'b1);
        fillImpulse(2 * Amp);
        runFrame("back to back", 1'b0);
    endtask

    initial begin : mainSequence
        seed       = 32'h2538;
        errorCount = 0;
        checkCount = 0;
        arstN      = 1'b0;
        loadEn     = 1'b0;
        loadAddr   = '0;
        loadData   = '0;
        start      = 1'b0;
        readAddr   = '0;
        repeat (5) @(posedge clk);
        arstN <= 1'b1;
        @(negedge clk);
        checkValue("reset", "busy after reset", 0, busy);
        checkValue("reset", "done after reset", 0, done);
        impulseTest();
        dcTest();
        nyquistTest();
        quarterRateTest();
        controlTest();
        errorCount += u_dut.u_sva.assertFailures;
        $display("Checks: %0d, errors: %0d", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

    initial begin : watchdog
        cycleCount = 0;
        while (cycleCount < CycleLimit) begin
            @(posedge clk);
            cycleCount++;
        end
        $display("Timeout: the tests did not finish within %0d cycles", CycleLimit);
        $display("** FAIL **");
        $finish;
    end

endmodule

// File: twiddleRom.sv
module twiddleRom #(
    parameter int FftSize = 1024
) (
    input  logic                         clk,
    input  logic [fftPkg::AddrWidth-2:0] twIdx,
    output fftPkg::twiddleT              tw
);
    import fftPkg::*;

    localparam int  Log2Size = $clog2(FftSize);
    localparam int  HalfSize = FftSize / 2;
    localparam real Pi       = 3.14159265358979323846;
    localparam real Scale    = real'(1 << TwiddleFrac);

    twiddleT romTable [HalfSize];

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // Entry i holds the factor for angle index bitReverse(i)
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    initial begin : buildTable
        real angle;
        int  k;
        for (int i = 0; i < HalfSize; i++) begin
            k     = int'(bitReverse(AddrWidth'(i), Log2Size - 1));
            angle = 2.0 * Pi * real'(k) / real'(FftSize);
            // Rounded to nearest, so cos(pi/2) comes out as an exact zero
            romTable[i].cos    = TwiddleWidth'($rtoi($floor($cos(angle) * Scale + 0.5)));
            romTable[i].negSin = TwiddleWidth'($rtoi($floor(-$sin(angle) * Scale + 0.5)));
        end
    end

    always_ff @(posedge clk) begin
        tw <= romTable[twIdx[Log2Size-2:0]];  // Same cycle as the sample reads
    end

endmodule
